// File: rtl/alu_adder.sv
`timescale 1ns/10ps
`default_nettype none

module alu_adder (
  input  wire [alu_pkg::xlen-1:0] src1_i,
  input  wire [alu_pkg::xlen-1:0] src2_i,
  input  wire                     sub_i,
  input  wire                     unsigned_cmp_i,
  output logic [alu_pkg::xlen-1:0] sum_o,
  output logic                    zero_o,
  output logic                    less_o
);

  logic [alu_pkg::xlen-1:0] b_inv;
  logic                     carry;
  logic                     overflow;

  // subtract as src1 + ~src2 + 1
  assign b_inv = src2_i ^ {alu_pkg::xlen{sub_i}};

  always_comb begin
    {carry, sum_o} = {1'b0, src1_i} + {1'b0, b_inv} + {{alu_pkg::xlen{1'b0}}, sub_i};
    overflow = (src1_i[alu_pkg::xlen-1] == b_inv[alu_pkg::xlen-1]) &&
               (sum_o[alu_pkg::xlen-1] != src1_i[alu_pkg::xlen-1]);
  end

  // no carry out of a - b means a borrow, so a < b unsigned
  assign less_o = unsigned_cmp_i ? ~carry : (sum_o[alu_pkg::xlen-1] ^ overflow);
  assign zero_o = ~(|sum_o);

endmodule

`default_nettype wire

// File: rtl/alu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module alu_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire alu_pkg::alu_req_t  req_i,
  input  wire                     flush_i,
  input  wire [alu_pkg::xlen-1:0] sum_i,
  input  wire [alu_pkg::xlen-1:0] shift_i,
  input  wire [alu_pkg::xlen-1:0] mul_res_i,
  input  wire [alu_pkg::xlen-1:0] div_res_i,
  input  wire                     less_i,
  input  wire                     mul_done_i,
  input  wire                     div_done_i,
  output logic                    sub_o,
  output logic                    unsigned_cmp_o,
  output logic                    right_o,
  output logic                    arith_o,
  output logic                    word_o,
  output logic                    mul_start_o,
  output logic                    div_start_o,
  output logic                    abort_o,
  output alu_pkg::md_op_e         md_op_o,
  output logic                    busy_o,
  output logic [alu_pkg::xlen-1:0] result_o
);

  alu_pkg::md_state_e       state_q;
  alu_pkg::md_state_e       state_d;
  alu_pkg::res_sel_e        sel;
  logic                     is_div;
  logic                     launch;
  logic [alu_pkg::xlen-1:0] raw;

  // op decode
  always_comb begin
    sub_o          = 1'b0;
    unsigned_cmp_o = 1'b0;
    right_o        = 1'b0;
    arith_o        = 1'b0;
    sel            = alu_pkg::sel_adder;
    case (req_i.alu_op)
      alu_pkg::op_add:    sel = alu_pkg::sel_adder;
      alu_pkg::op_sub:    sub_o = 1'b1;
      alu_pkg::op_sll:    sel = alu_pkg::sel_shift;
      alu_pkg::op_slt: begin
        sub_o = 1'b1;
        sel   = alu_pkg::sel_less;
      end
      alu_pkg::op_sltu: begin
        sub_o          = 1'b1;
        unsigned_cmp_o = 1'b1;
        sel            = alu_pkg::sel_less;
      end
      alu_pkg::op_srl: begin
        right_o = 1'b1;
        sel     = alu_pkg::sel_shift;
      end
      alu_pkg::op_sra: begin
        right_o = 1'b1;
        arith_o = 1'b1;
        sel     = alu_pkg::sel_shift;
      end
      alu_pkg::op_pass_b: sel = alu_pkg::sel_b;
      alu_pkg::op_xor:    sel = alu_pkg::sel_xor;
      alu_pkg::op_or:     sel = alu_pkg::sel_or;
      alu_pkg::op_and:    sel = alu_pkg::sel_and;
      default:            sel = alu_pkg::sel_adder;
    endcase
    if (req_i.md_en) begin
      sel = alu_pkg::sel_md;
    end
  end

  assign word_o  = req_i.word;
  assign md_op_o = req_i.md_op;
  assign abort_o = flush_i;
  assign is_div  = req_i.md_op inside {alu_pkg::md_div, alu_pkg::md_divu,
                                       alu_pkg::md_rem, alu_pkg::md_remu};

  // cycle 0 of a multicycle op, start goes only to the selected unit
  assign launch      = (state_q == alu_pkg::st_idle) && req_i.md_en && !flush_i;
  assign mul_start_o = launch && !is_div;
  assign div_start_o = launch && is_div;
  assign busy_o      = launch || ((state_q == alu_pkg::st_run) && !flush_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      alu_pkg::st_idle: begin
        if (launch) state_d = alu_pkg::st_run;
      end
      alu_pkg::st_run: begin
        if (flush_i) state_d = alu_pkg::st_idle;
        else if (mul_done_i || div_done_i) state_d = alu_pkg::st_done;
      end
      alu_pkg::st_done: begin
        // hold the result until the request drops
        if (flush_i || !req_i.md_en) state_d = alu_pkg::st_idle;
      end
      default: state_d = alu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= alu_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    case (sel)
      alu_pkg::sel_adder: raw = sum_i;
      alu_pkg::sel_shift: raw = shift_i;
      alu_pkg::sel_less:  raw = {{(alu_pkg::xlen-1){1'b0}}, less_i};
      alu_pkg::sel_b:     raw = req_i.src2;
      alu_pkg::sel_xor:   raw = req_i.src1 ^ req_i.src2;
      alu_pkg::sel_or:    raw = req_i.src1 | req_i.src2;
      alu_pkg::sel_and:   raw = req_i.src1 & req_i.src2;
      alu_pkg::sel_md:    raw = is_div ? div_res_i : mul_res_i;
      default:            raw = sum_i;
    endcase
    // word variants sign-extend the low half
    if (req_i.word && !req_i.md_en) begin
      result_o = {{32{raw[31]}}, raw[31:0]};
    end else begin
      result_o = raw;
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu_div.sv
`timescale 1ns/10ps
`default_nettype none

module alu_div (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start_i,
  input  wire                     abort_i,
  input  wire alu_pkg::md_op_e    md_op_i,
  input  wire [alu_pkg::xlen-1:0] src1_i,
  input  wire [alu_pkg::xlen-1:0] src2_i,
  output logic                    done_o,
  output logic [alu_pkg::xlen-1:0] result_o
);

  logic [alu_pkg::xlen-1:0]     rem_q;
  logic [alu_pkg::xlen-1:0]     quo_q;
  logic [alu_pkg::xlen-1:0]     dvs_q;
  logic [alu_pkg::md_cnt_w-1:0] cnt_q;
  logic                         running_q;
  logic                         q_neg_q;
  logic                         r_neg_q;
  alu_pkg::md_op_e              op_q;
  logic                         signed_op;
  logic                         a_neg;
  logic                         b_neg;
  logic [alu_pkg::xlen-1:0]     a_mag;
  logic [alu_pkg::xlen-1:0]     b_mag;
  logic [alu_pkg::xlen:0]       shifted;
  logic [alu_pkg::xlen+1:0]     diff;
  logic                         ge;

  always_comb begin
    signed_op = (md_op_i == alu_pkg::md_div) || (md_op_i == alu_pkg::md_rem);
    a_neg = signed_op && src1_i[alu_pkg::xlen-1];
    b_neg = signed_op && src2_i[alu_pkg::xlen-1];
    a_mag = a_neg ? -src1_i : src1_i;
    b_mag = b_neg ? -src2_i : src2_i;
  end

  // trial subtract of the divisor from the shifted partial remainder
  assign shifted = {rem_q, quo_q[alu_pkg::xlen-1]};
  assign diff = {1'b0, shifted} - {2'b00, dvs_q};
  assign ge = ~diff[alu_pkg::xlen+1];

  assign done_o = running_q && (cnt_q == alu_pkg::md_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem_q     <= '0;
      quo_q     <= '0;
      dvs_q     <= '0;
      cnt_q     <= '0;
      running_q <= 1'b0;
      q_neg_q   <= 1'b0;
      r_neg_q   <= 1'b0;
      op_q      <= alu_pkg::md_div;
    end else if (abort_i) begin
      running_q <= 1'b0;
    end else if (start_i) begin
      rem_q     <= '0;
      quo_q     <= a_mag;
      dvs_q     <= b_mag;
      cnt_q     <= '0;
      running_q <= 1'b1;
      // zero divisor must keep the all-ones quotient
      q_neg_q   <= (a_neg ^ b_neg) && (src2_i != '0);
      r_neg_q   <= a_neg;
      op_q      <= md_op_i;
    end else if (running_q) begin
      rem_q <= ge ? diff[alu_pkg::xlen-1:0] : shifted[alu_pkg::xlen-1:0];
      quo_q <= {quo_q[alu_pkg::xlen-2:0], ge};
      cnt_q <= cnt_q + 1'b1;
      if (done_o) begin
        running_q <= 1'b0;
      end
    end
  end

  // min / -1 needs no patch: magnitude 2^63 negates back to itself
  always_comb begin
    if ((op_q == alu_pkg::md_div) || (op_q == alu_pkg::md_divu)) begin
      result_o = q_neg_q ? -quo_q : quo_q;
    end else begin
      result_o = r_neg_q ? -rem_q : rem_q;
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu_mul.sv
`timescale 1ns/10ps
`default_nettype none

module alu_mul (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start_i,
  input  wire                     abort_i,
  input  wire alu_pkg::md_op_e    md_op_i,
  input  wire [alu_pkg::xlen-1:0] src1_i,
  input  wire [alu_pkg::xlen-1:0] src2_i,
  output logic                    done_o,
  output logic [alu_pkg::xlen-1:0] result_o
);

  logic [alu_pkg::xlen-1:0]     hi_q;
  logic [alu_pkg::xlen-1:0]     lo_q;
  logic [alu_pkg::xlen-1:0]     mcand_q;
  logic [alu_pkg::md_cnt_w-1:0] cnt_q;
  logic                         running_q;
  logic                         neg_q;
  alu_pkg::md_op_e              op_q;
  logic                         a_neg;
  logic                         b_neg;
  logic [alu_pkg::xlen-1:0]     a_mag;
  logic [alu_pkg::xlen-1:0]     b_mag;
  logic [alu_pkg::xlen:0]       add_res;
  logic [2*alu_pkg::xlen-1:0]   prod;

  always_comb begin
    // mulh: both signed, mulhsu: only src1 signed
    a_neg = ((md_op_i == alu_pkg::md_mulh) || (md_op_i == alu_pkg::md_mulhsu)) &&
            src1_i[alu_pkg::xlen-1];
    b_neg = (md_op_i == alu_pkg::md_mulh) && src2_i[alu_pkg::xlen-1];
    a_mag = a_neg ? -src1_i : src1_i;
    b_mag = b_neg ? -src2_i : src2_i;
  end

  // add the multiplicand into the high half when the multiplier bit is set
  assign add_res = lo_q[0] ? ({1'b0, hi_q} + {1'b0, mcand_q}) : {1'b0, hi_q};

  assign done_o = running_q && (cnt_q == alu_pkg::md_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hi_q      <= '0;
      lo_q      <= '0;
      mcand_q   <= '0;
      cnt_q     <= '0;
      running_q <= 1'b0;
      neg_q     <= 1'b0;
      op_q      <= alu_pkg::md_mul;
    end else if (abort_i) begin
      running_q <= 1'b0;
    end else if (start_i) begin
      hi_q      <= '0;
      lo_q      <= b_mag;
      mcand_q   <= a_mag;
      cnt_q     <= '0;
      running_q <= 1'b1;
      neg_q     <= a_neg ^ b_neg;
      op_q      <= md_op_i;
    end else if (running_q) begin
      // shift product right, carry enters at the top
      hi_q  <= add_res[alu_pkg::xlen:1];
      lo_q  <= {add_res[0], lo_q[alu_pkg::xlen-1:1]};
      cnt_q <= cnt_q + 1'b1;
      if (done_o) begin
        running_q <= 1'b0;
      end
    end
  end

  assign prod = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
  assign result_o = (op_q == alu_pkg::md_mul) ? prod[alu_pkg::xlen-1:0] :
                                                prod[2*alu_pkg::xlen-1:alu_pkg::xlen];

endmodule

`default_nettype wire

// File: rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int xlen = 64;

  // iteration cycles of the multiply and divide units
  localparam int md_cycles = 64;
  localparam int md_cnt_w = $clog2(md_cycles);
  localparam logic [md_cnt_w-1:0] md_last = md_cnt_w'(md_cycles - 1);

  // single-cycle operations
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_srl,
    op_sra,
    op_pass_b,
    op_xor,
    op_or,
    op_and
  } alu_op_e;

  // M-extension operations, divide group in the upper half
  typedef enum logic [2:0] {
    md_mul,
    md_mulh,
    md_mulhsu,
    md_mulhu,
    md_div,
    md_divu,
    md_rem,
    md_remu
  } md_op_e;

  typedef struct packed {
    alu_op_e             alu_op;
    md_op_e              md_op;
    logic                md_en;
    logic                word;
    logic [xlen-1:0]     src1;
    logic [xlen-1:0]     src2;
  } alu_req_t;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } md_state_e;

  typedef enum logic [2:0] {
    sel_adder,
    sel_shift,
    sel_less,
    sel_b,
    sel_xor,
    sel_or,
    sel_and,
    sel_md
  } res_sel_e;

endpackage

`default_nettype wire

// File: rtl/alu_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module alu_shifter (
  input  wire [alu_pkg::xlen-1:0] src_i,
  input  wire [5:0]               shamt_i,
  input  wire                     right_i,
  input  wire                     arith_i,
  input  wire                     word_i,
  output logic [alu_pkg::xlen-1:0] shift_o
);

  logic [5:0]                  amt;
  logic [alu_pkg::xlen-1:0]    src_ext;
  logic [alu_pkg::xlen-1:0]    shr_in;
  logic [alu_pkg::xlen-1:0]    shr_out;
  logic signed [alu_pkg::xlen:0] shr_wide;
  logic                        fill;

  always_comb begin
    // word shifts only use five amount bits
    amt = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

    // in word mode bit 31 acts as the sign for right shifts
    if (word_i) begin
      src_ext = {{32{arith_i & src_i[31]}}, src_i[31:0]};
    end else begin
      src_ext = src_i;
    end
    fill = right_i & arith_i & src_ext[alu_pkg::xlen-1];

    // left shift runs through the right shifter on reversed bits
    for (int i = 0; i < alu_pkg::xlen; i++) begin
      shr_in[i] = right_i ? src_ext[i] : src_ext[alu_pkg::xlen-1-i];
    end

    shr_wide = $signed({fill, shr_in}) >>> amt;
    shr_out = shr_wide[alu_pkg::xlen-1:0];

    for (int i = 0; i < alu_pkg::xlen; i++) begin
      shift_o[i] = right_i ? shr_out[i] : shr_out[alu_pkg::xlen-1-i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/alu_top.sv
`timescale 1ns/10ps
`default_nettype none

module alu_top (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire alu_pkg::alu_req_t   req_i,
  input  wire                      flush_i,
  output logic [alu_pkg::xlen-1:0] result_o,
  output logic                     less_o,
  output logic                     zero_o,
  output logic                     busy_o
);

  logic [alu_pkg::xlen-1:0] sum;
  logic [alu_pkg::xlen-1:0] shift;
  logic [alu_pkg::xlen-1:0] mul_res;
  logic [alu_pkg::xlen-1:0] div_res;
  logic                     sub;
  logic                     unsigned_cmp;
  logic                     right;
  logic                     arith;
  logic                     word;
  logic                     mul_start;
  logic                     div_start;
  logic                     mul_done;
  logic                     div_done;
  logic                     abort;
  alu_pkg::md_op_e          md_op;

  alu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .flush_i        (flush_i),
    .sum_i          (sum),
    .shift_i        (shift),
    .mul_res_i      (mul_res),
    .div_res_i      (div_res),
    .less_i         (less_o),
    .mul_done_i     (mul_done),
    .div_done_i     (div_done),
    .sub_o          (sub),
    .unsigned_cmp_o (unsigned_cmp),
    .right_o        (right),
    .arith_o        (arith),
    .word_o         (word),
    .mul_start_o    (mul_start),
    .div_start_o    (div_start),
    .abort_o        (abort),
    .md_op_o        (md_op),
    .busy_o         (busy_o),
    .result_o       (result_o)
  );

  // flags go out straight from the adder
  alu_adder u_adder (
    .src1_i         (req_i.src1),
    .src2_i         (req_i.src2),
    .sub_i          (sub),
    .unsigned_cmp_i (unsigned_cmp),
    .sum_o          (sum),
    .zero_o         (zero_o),
    .less_o         (less_o)
  );

  alu_shifter u_shifter (
    .src_i   (req_i.src1),
    .shamt_i (req_i.src2[5:0]),
    .right_i (right),
    .arith_i (arith),
    .word_i  (word),
    .shift_o (shift)
  );

  alu_mul u_mul (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .abort_i  (abort),
    .md_op_i  (md_op),
    .src1_i   (req_i.src1),
    .src2_i   (req_i.src2),
    .done_o   (mul_done),
    .result_o (mul_res)
  );

  alu_div u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start),
    .abort_i  (abort),
    .md_op_i  (md_op),
    .src1_i   (req_i.src1),
    .src2_i   (req_i.src2),
    .done_o   (div_done),
    .result_o (div_res)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the execution unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module alu_tb -f verilog.f -o alu_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/alu_sim > sim.log 2>&1 || true

grep -qx ">>> PASS" sim.log \
  && { cat sim.log; echo "simulation passed"; } \
  || { cat sim.log; echo "simulation failed"; exit 1; }

// File: testbench/alu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module alu_chk (
  input wire clk,
  input wire rst_n,
  input wire md_en_i,
  input wire flush_i,
  input wire busy_i
);

  // controller sits in st_idle while reset is held
  busy_low_in_reset: assert property (@(posedge clk) !rst_n |-> !busy_i)
    else $error("busy_o high while rst_n is asserted");

  // only a multicycle request can raise busy
  busy_needs_md_en: assert property (@(posedge clk) disable iff (!rst_n)
                                     $rose(busy_i) |-> md_en_i)
    else $error("busy_o rose without md_en in the request");

  // flush leaves no run behind once the request is withdrawn
  busy_drops_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
                                        ($past(flush_i) && !md_en_i) |-> !busy_i)
    else $error("busy_o still high the cycle after flush_i");

endmodule

bind alu_top alu_chk u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .md_en_i (req_i.md_en),
  .flush_i (flush_i),
  .busy_i  (busy_o)
);

`default_nettype wire

// File: testbench/alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module alu_tb;

  typedef logic [alu_pkg::xlen-1:0] data_t;

  localparam int n_simple    = 400;
  localparam int n_flag_rand = 30;
  localparam int n_edge      = 8;
  localparam int n_mul       = 40;
  localparam int n_div       = 40;
  localparam int n_flush     = 2;
  localparam int busy_len    = alu_pkg::md_cycles + 1;
  // busy cycles plus hold, release and a spare cycle per request
  localparam int md_req_cycles  = busy_len + 5;
  localparam int timeout_cycles = n_simple + n_flag_rand + 3 * n_edge
                                  + (n_mul + n_div + 2 * n_flush) * md_req_cycles + 200;

  localparam data_t min_val = {1'b1, {(alu_pkg::xlen-1){1'b0}}};
  localparam data_t max_val = {1'b0, {(alu_pkg::xlen-1){1'b1}}};

  logic              clk;
  logic              rst_n;
  alu_pkg::alu_req_t req;
  logic              flush;
  data_t             result;
  logic              less;
  logic              zero;
  logic              busy;

  logic [31:0] rng_state;
  int          cycle_cnt;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;

  alu_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req),
    .flush_i  (flush),
    .result_o (result),
    .less_o   (less),
    .zero_o   (zero),
    .busy_o   (busy)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not end within %0d clock cycles", timeout_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // only the upper half of each draw, low LCG bits repeat quickly
  function automatic data_t rand_data();
    data_t       v;
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r = next_rand();
      v[16*i +: 16] = r[31:16];
    end
    return v;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  function automatic data_t model_simple(input alu_pkg::alu_op_e op, input logic word,
                                         input data_t a, input data_t b);
    data_t              r;
    logic [5:0]         sh;
    logic [31:0]        w;
    logic signed [63:0] sa;
    logic signed [31:0] sw;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    w  = a[31:0];
    sa = a;
    sw = a[31:0];
    case (op)
      alu_pkg::op_add:    r = a + b;
      alu_pkg::op_sub:    r = a - b;
      alu_pkg::op_sll:    r = word ? {32'b0, w << sh} : a << sh;
      alu_pkg::op_slt:    r = {63'b0, $signed(a) < $signed(b)};
      alu_pkg::op_sltu:   r = {63'b0, a < b};
      alu_pkg::op_srl:    r = word ? {32'b0, w >> sh} : a >> sh;
      alu_pkg::op_sra: begin
        if (word) begin
          r = {32'b0, sw >>> sh};
        end else begin
          r = sa >>> sh;
        end
      end
      alu_pkg::op_pass_b: r = b;
      alu_pkg::op_xor:    r = a ^ b;
      alu_pkg::op_or:     r = a | b;
      default:            r = a & b;
    endcase
    // word forms keep the low 32 bits, sign-extended
    if (word) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    return r;
  endfunction

  function automatic data_t model_md(input alu_pkg::md_op_e op, input data_t a, input data_t b);
    logic [127:0]       sx_a;
    logic [127:0]       sx_b;
    logic [127:0]       zx_a;
    logic [127:0]       zx_b;
    logic [127:0]       prod;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    data_t              r;
    sx_a = {{64{a[63]}}, a};
    sx_b = {{64{b[63]}}, b};
    zx_a = {64'b0, a};
    zx_b = {64'b0, b};
    sa   = a;
    sb   = b;
    case (op)
      alu_pkg::md_mulh:   prod = sx_a * sx_b;
      alu_pkg::md_mulhsu: prod = sx_a * zx_b;
      default:            prod = zx_a * zx_b;
    endcase
    case (op)
      alu_pkg::md_mul:  r = prod[63:0];
      alu_pkg::md_divu: r = (b == 0) ? '1 : a / b;
      alu_pkg::md_remu: r = (b == 0) ? a : a % b;
      alu_pkg::md_div: begin
        if (b == 0) r = '1;
        else if (a == min_val && b == '1) r = min_val;
        else r = sa / sb;
      end
      alu_pkg::md_rem: begin
        if (b == 0) r = a;
        else if (a == min_val && b == '1) r = '0;
        else r = sa % sb;
      end
      default:          r = prod[127:64];
    endcase
    return r;
  endfunction

  task automatic check_val(input string name, input data_t exp, input data_t got);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test();
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    $display("test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
  endtask

  task automatic apply_simple(input alu_pkg::alu_op_e op, input logic word,
                              input data_t a, input data_t b);
    @(posedge clk);
    #1;
    req        = '0;
    req.alu_op = op;
    req.word   = word;
    req.src1   = a;
    req.src2   = b;
    @(negedge clk);
  endtask

  task automatic check_flags(input alu_pkg::alu_op_e op, input data_t a, input data_t b);
    logic exp_less;
    if (op == alu_pkg::op_sltu) begin
      exp_less = a < b;
    end else begin
      exp_less = $signed(a) < $signed(b);
    end
    apply_simple(op, 1'b0, a, b);
    check_val("less_o", exp_less, less);
    check_val("zero_o", a == b, zero);
    check_val("result_o", model_simple(op, 1'b0, a, b), result);
  endtask

  // one multicycle request, held until the result is seen, then released
  task automatic apply_md(input alu_pkg::md_op_e op, input data_t a, input data_t b);
    data_t exp;
    int    cycles;
    exp = model_md(op, a, b);
    @(posedge clk);
    #1;
    req       = '0;
    req.md_en = 1'b1;
    req.md_op = op;
    req.src1  = a;
    req.src2  = b;
    cycles    = 0;
    @(negedge clk);
    while (busy && cycles <= busy_len) begin
      cycles++;
      @(negedge clk);
    end
    check_val("busy_o high cycles", busy_len, cycles);
    check_val("result_o", exp, result);
    @(negedge clk);
    check_val("result_o", exp, result);
    check_val("busy_o", 0, busy);
    @(posedge clk);
    #1;
    req.md_en = 1'b0;
  endtask

  task automatic test_simple();
    alu_pkg::alu_op_e op;
    logic             word;
    data_t            a;
    data_t            b;
    start_test();
    for (int i = 0; i < n_simple; i++) begin
      op   = alu_pkg::alu_op_e'(pick(11));
      word = pick(2) == 1;
      a    = rand_data();
      b    = rand_data();
      apply_simple(op, word, a, b);
      check_val("result_o", model_simple(op, word, a, b), result);
      check_val("busy_o", 0, busy);
    end
    end_test("simple_ops");
  endtask

  task automatic test_flags();
    data_t            edge_a [n_edge];
    data_t            edge_b [n_edge];
    alu_pkg::alu_op_e cmp_ops [3];
    data_t            a;
    data_t            b;
    edge_a  = '{64'd0, min_val, min_val, max_val, min_val, 64'd0, '1, 64'd5};
    edge_b  = '{64'd0, min_val, max_val, min_val, 64'd1, '1, 64'd0, 64'd5};
    cmp_ops = '{alu_pkg::op_sub, alu_pkg::op_slt, alu_pkg::op_sltu};
    start_test();
    for (int i = 0; i < n_edge; i++) begin
      for (int k = 0; k < 3; k++) begin
        check_flags(cmp_ops[k], edge_a[i], edge_b[i]);
      end
    end
    for (int i = 0; i < n_flag_rand; i++) begin
      a = rand_data();
      b = (i % 4 == 0) ? a : rand_data();
      check_flags(cmp_ops[pick(3)], a, b);
    end
    end_test("flags");
  endtask

  task automatic test_mul();
    alu_pkg::md_op_e op;
    data_t           a;
    data_t           b;
    start_test();
    for (int i = 0; i < n_mul; i++) begin
      op = alu_pkg::md_op_e'(pick(4));
      a  = (i % 10 == 0) ? min_val : rand_data();
      b  = (i % 10 == 1) ? '1 : rand_data();
      apply_md(op, a, b);
    end
    end_test("multiply");
  endtask

  task automatic test_div();
    alu_pkg::md_op_e op;
    data_t           a;
    data_t           b;
    start_test();
    for (int i = 0; i < n_div; i++) begin
      op = alu_pkg::md_op_e'(4 + pick(4));
      a  = rand_data();
      // spread divisor sizes so quotients are not all 0 or 1
      b  = rand_data() >> pick(64);
      case (i % 8)
        0: b = '0;
        1: begin
          a  = min_val;
          b  = '1;
          op = alu_pkg::md_div;
        end
        2: begin
          a  = min_val;
          b  = '1;
          op = alu_pkg::md_rem;
        end
        default: ;
      endcase
      apply_md(op, a, b);
    end
    end_test("divide");
  endtask

  task automatic test_flush();
    alu_pkg::md_op_e op;
    start_test();
    for (int i = 0; i < n_flush; i++) begin
      op = (i == 0) ? alu_pkg::md_mulh : alu_pkg::md_div;
      @(posedge clk);
      #1;
      req       = '0;
      req.md_en = 1'b1;
      req.md_op = op;
      req.src1  = rand_data();
      req.src2  = rand_data();
      // abort partway through the iterations
      repeat (20) @(posedge clk);
      @(negedge clk);
      check_val("busy_o", 1, busy);
      @(posedge clk);
      #1;
      flush = 1'b1;
      @(negedge clk);
      check_val("busy_o", 0, busy);
      @(posedge clk);
      #1;
      flush     = 1'b0;
      req.md_en = 1'b0;
      @(negedge clk);
      check_val("busy_o", 0, busy);
      apply_md(op, rand_data(), rand_data());
    end
    end_test("flush");
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    flush     = 1'b0;
    rng_state = 32'h1a30;
    cycle_cnt = 0;
    checks    = 0;
    errors    = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_simple();
    test_flags();
    test_mul();
    test_div();
    test_flush();
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/alu_pkg.sv
rtl/alu_adder.sv
rtl/alu_shifter.sv
rtl/alu_mul.sv
rtl/alu_div.sv
rtl/alu_ctrl.sv
rtl/alu_top.sv
testbench/alu_chk.sv
testbench/alu_tb.sv
